/* sources.f */
hdl/prfPkg.sv
hdl/prfWriteSelect.sv
hdl/prfStorage.sv
hdl/prfReadMux.sv
hdl/physRegFile.sv
tb/physRegFile_assertions.sv
tb/physRegFileTb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the register file testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module physRegFileTb -f sources.f -Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/simv" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "Everything OK" "$LOG_FILE"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

/* tb/physRegFileTb.sv */
// One table row per cycle with reads checked at the falling edge before that row's writes land
`default_nettype none

module physRegFileTb
  import prfPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int resetCycles = 4;

  typedef struct packed {
    prfWrite_t    [issueWidth-1:0] write;
    prfDebug_t                     debug;
    prfLaneRead_t [issueWidth-1:0] read;
  } stimRow_t;

  logic                          clk = 1'b0;
  logic                          reset = 1'b1;
  prfLaneRead_t [issueWidth-1:0] laneRead = '0;
  prfWrite_t    [issueWidth-1:0] laneWrite = '0;
  prfDebug_t                     debugReq = '0;
  prfLaneData_t [issueWidth-1:0] laneData;
  prfData_t                      debugRdData;

  stimRow_t stimTable [$];
  prfData_t model [numEntries];       // Expected register contents
  int       mismatchCount = 0;
  int       otherCount = 0;
  int       cycleCount = 0;
  int       cycleLimit = 0;

  always #10 clk = ~clk;

  physRegFile physRegFile_inst
  (
    .clk           (clk),
    .reset         (reset),
    .laneRead_i    (laneRead),
    .laneData_o    (laneData),
    .laneWrite_i   (laneWrite),
    .debug_i       (debugReq),
    .debugRdData_o (debugRdData)
  );

  function automatic prfOneHot_t oneHot(input int idx);
    return prfOneHot_t'(1) << idx;
  endfunction

  function automatic prfOneHot_t pickAddr();
    if (($urandom() % 2) == 0)
    begin
      return oneHot($urandom_range(numEntries - 1, 0));
    end
    return prfOneHot_t'($urandom());  // Mostly multi-hot
  endfunction

  function automatic prfWrite_t writeReq(input logic we, input prfOneHot_t addr);
    prfWrite_t req;
    req.we   = we;
    req.addr = addr;
    req.data = prfData_t'($urandom());
    return req;
  endfunction

  function automatic prfDebug_t debugAccess(input logic we, input prfOneHot_t addr);
    prfDebug_t req;
    req.we     = we;
    req.addr   = addr;
    req.wrData = prfData_t'($urandom());
    return req;
  endfunction

  function automatic prfLaneRead_t readPair(input prfOneHot_t src1, input prfOneHot_t src2);
    prfLaneRead_t pair;
    pair.src1 = src1;
    pair.src2 = src2;
    return pair;
  endfunction

  task automatic addRow(input prfWrite_t w0, input prfWrite_t w1, input prfDebug_t dbg,
                        input prfLaneRead_t r0, input prfLaneRead_t r1);
    stimRow_t row;
    row.write = {w1, w0};
    row.debug = dbg;
    row.read  = {r1, r0};
    stimTable.push_back(row);
  endtask

  task automatic buildTable();
    prfWrite_t idle;
    idle = writeReq(1'b0, '0);
    repeat (3)
    begin
      addRow(idle, idle, debugAccess(1'b0, pickAddr()), readPair(pickAddr(), pickAddr()),
             readPair(pickAddr(), pickAddr()));
    end
    // Same-cycle read sees old value
    addRow(writeReq(1'b1, oneHot(3)), idle, debugAccess(1'b0, oneHot(3)),
           readPair(oneHot(3), oneHot(3)), readPair(oneHot(3), '0));
    addRow(idle, idle, debugAccess(1'b0, oneHot(3)), readPair(oneHot(3), oneHot(3)),
           readPair(oneHot(3), oneHot(3)));
    // Collisions on entry 5
    addRow(writeReq(1'b1, oneHot(5)), writeReq(1'b1, oneHot(5)), debugAccess(1'b0, oneHot(5)),
           readPair(oneHot(5), oneHot(3)), readPair(oneHot(5), oneHot(5)));
    addRow(writeReq(1'b1, oneHot(5)), writeReq(1'b1, oneHot(5)), debugAccess(1'b1, oneHot(5)),
           readPair(oneHot(5), oneHot(3)), readPair(oneHot(5), oneHot(5)));
    addRow(idle, idle, debugAccess(1'b0, oneHot(5)), readPair(oneHot(5), oneHot(4)),
           readPair(oneHot(6), oneHot(5)));
    // Debug write touches entry 9 only
    addRow(idle, idle, debugAccess(1'b1, oneHot(9)), readPair(oneHot(8), oneHot(10)),
           readPair(oneHot(9), oneHot(3)));
    addRow(idle, idle, debugAccess(1'b0, oneHot(9)), readPair(oneHot(8), oneHot(10)),
           readPair(oneHot(9), oneHot(0)));
    // Multi-hot and empty addresses
    addRow(idle, writeReq(1'b1, oneHot(0)), debugAccess(1'b0, oneHot(0)),
           readPair('0, oneHot(0)), readPair(16'h0228, '0));
    addRow(idle, idle, debugAccess(1'b0, 16'h0228), readPair(16'h0000, 16'h0001),
           readPair(16'h0228, 16'h003c));
    // Three writes to separate entries at once
    addRow(writeReq(1'b1, oneHot(1)), writeReq(1'b1, oneHot(2)), debugAccess(1'b1, oneHot(4)),
           readPair(oneHot(1), oneHot(2)), readPair(oneHot(4), '0));
    addRow(idle, idle, debugAccess(1'b0, oneHot(4)), readPair(oneHot(1), oneHot(2)),
           readPair(oneHot(4), 16'h0016));
    for (int r = 0; r < 24; r++)
    begin
      addRow(writeReq(($urandom() % 4) != 0, oneHot($urandom_range(numEntries - 1, 0))),
             writeReq(($urandom() % 4) != 0, oneHot($urandom_range(numEntries - 1, 0))),
             debugAccess(($urandom() % 4) == 0, oneHot($urandom_range(numEntries - 1, 0))),
             readPair(pickAddr(), pickAddr()), readPair(pickAddr(), pickAddr()));
    end
    addRow(idle, idle, debugAccess(1'b0, pickAddr()), readPair(pickAddr(), pickAddr()),
           readPair(pickAddr(), pickAddr()));
  endtask

  // Highest selected entry or entry 0 when nothing above it is set
  function automatic prfData_t expectRead(input prfOneHot_t addr);
    int e;
    e = numEntries - 1;
    while (e > 0 && !addr[e])
    begin
      e--;
    end
    return model[e];
  endfunction

  task automatic updateModel(input stimRow_t row);
    for (int e = 0; e < numEntries; e++)
    begin
      for (int g = 0; g < issueWidth; g++)
      begin
        if (row.write[g].we && row.write[g].addr[e])
        begin
          model[e] = row.write[g].data;   // Later lane overrides
        end
      end
      if (row.debug.we && row.debug.addr[e])
      begin
        model[e] = row.debug.wrData;
      end
    end
  endtask

  task automatic checkLane(input string name, input prfLaneData_t got, input prfLaneData_t exp);
    if ($isunknown(got))
    begin
      otherCount++;
      $display("Error: %s carries unknown bits", name);
    end
    else if (got !== exp)
    begin
      mismatchCount++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkData(input string name, input prfData_t got, input prfData_t exp);
    if ($isunknown(got))
    begin
      otherCount++;
      $display("Error: %s carries unknown bits", name);
    end
    else if (got !== exp)
    begin
      mismatchCount++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic verifyReads(input stimRow_t row, input int idx);
    prfLaneData_t expLane;
    for (int g = 0; g < issueWidth; g++)
    begin
      expLane.src1 = expectRead(row.read[g].src1);
      expLane.src2 = expectRead(row.read[g].src2);
      checkLane($sformatf("laneData_o[%0d] row %0d", g, idx), laneData[g], expLane);
    end
    checkData($sformatf("debugRdData_o row %0d", idx), debugRdData, expectRead(row.debug.addr));
  endtask

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit)
    begin
      $display("Error: run did not finish within %0d cycles", cycleLimit);
      $display("Something failed");
      $finish;
    end
  end

  initial
  begin
    stimRow_t row;
    int       assertFails;
    void'($urandom(32'he169_b148));
    buildTable();
    cycleLimit = stimTable.size() + resetCycles + 20;
    foreach (model[e])
    begin
      model[e] = '0;
    end

    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;

    foreach (stimTable[r])
    begin
      row = stimTable[r];
      @(posedge clk);
      laneWrite <= row.write;
      debugReq  <= row.debug;
      laneRead  <= row.read;
      @(negedge clk);                 // Reads settled and writes still pending
      verifyReads(row, r);
      updateModel(row);
    end

    @(posedge clk);
    laneWrite <= '0;
    debugReq  <= '0;
    laneRead  <= '0;
    @(posedge clk);
    @(negedge clk);                   // Assertion actions of the last edge have run

    assertFails = physRegFile_inst.regFileChecks.failCount;
    $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
             mismatchCount, otherCount, assertFails);
    if (mismatchCount == 0 && otherCount == 0 && assertFails == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : physRegFileTb

`default_nettype wire

/* tb/physRegFile_assertions.sv */
// Needs the internal entries wire of physRegFile and keeps its own failure count for the testbench
`default_nettype none

module physRegFile_assertions
  import prfPkg::*;
(
  input wire                                clk,
  input wire                                reset,
  input wire prfLaneRead_t [issueWidth-1:0] laneRead_i,
  input wire prfLaneData_t [issueWidth-1:0] laneData_i,
  input wire prfDebug_t                     debug_i,
  input wire prfData_t                      debugRdData_i,
  input wire prfData_t [numEntries-1:0]     entries_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;

  // Storage was cleared by the previous edge
  resetClears: assert property (@(posedge clk) reset |=> (debugRdData_i == '0))
  else
  begin
    failCount++;
    $error("debug read data not zero in the cycle after reset");
  end

  for (genvar g = 0; g < issueWidth; g++)
  begin : gLane
    emptySrc1: assert property (@(posedge clk) disable iff (reset)
      (laneRead_i[g].src1 == '0) |-> (laneData_i[g].src1 == entries_i[0]))
    else
    begin
      failCount++;
      $error("lane %0d src1 with empty address does not read entry 0", g);
    end

    emptySrc2: assert property (@(posedge clk) disable iff (reset)
      (laneRead_i[g].src2 == '0) |-> (laneData_i[g].src2 == entries_i[0]))
    else
    begin
      failCount++;
      $error("lane %0d src2 with empty address does not read entry 0", g);
    end
  end

  debugEmpty: assert property (@(posedge clk) disable iff (reset)
    (debug_i.addr == '0) |-> (debugRdData_i == entries_i[0]))
  else
  begin
    failCount++;
    $error("debug read with empty address does not read entry 0");
  end

endmodule : physRegFile_assertions

bind physRegFile physRegFile_assertions regFileChecks
(
  .clk           (clk),
  .reset         (reset),
  .laneRead_i    (laneRead_i),
  .laneData_i    (laneData_o),
  .debug_i       (debug_i),
  .debugRdData_i (debugRdData_o),
  .entries_i     (entries)
);

`default_nettype wire

/* hdl/physRegFile.sv */
// Two-lane physical register file with one-hot addresses and a debug port whose write wins
`default_nettype none

module physRegFile
  import prfPkg::*;
(
  input  wire                                clk,
  input  wire                                reset,

  // Source reads of both lanes
  input  wire prfLaneRead_t [issueWidth-1:0] laneRead_i,
  output wire prfLaneData_t [issueWidth-1:0] laneData_o,

  // Destination writes of both lanes
  input  wire prfWrite_t    [issueWidth-1:0] laneWrite_i,

  // Debug access
  input  wire prfDebug_t                     debug_i,
  output wire prfData_t                      debugRdData_o
);

  wire prfOneHot_t                entryWe;
  wire prfData_t [numEntries-1:0] entryData;
  wire prfData_t [numEntries-1:0] entries;

  prfWriteSelect writeSelect
  (
    .laneWrite_i (laneWrite_i),
    .debug_i     (debug_i),
    .entryWe_o   (entryWe),
    .entryData_o (entryData)
  );

  prfStorage storage
  (
    .clk         (clk),
    .reset       (reset),
    .entryWe_i   (entryWe),
    .entryData_i (entryData),
    .entries_o   (entries)
  );

  // Two source ports per lane
  for (genvar g = 0; g < issueWidth; g++)
  begin : gLane
    prfReadMux src1Mux
    (
      .entries_i (entries),
      .addr_i    (laneRead_i[g].src1),
      .data_o    (laneData_o[g].src1)
    );

    prfReadMux src2Mux
    (
      .entries_i (entries),
      .addr_i    (laneRead_i[g].src2),
      .data_o    (laneData_o[g].src2)
    );
  end

  // Separate debug read port on the shared debug address
  prfReadMux debugMux
  (
    .entries_i (entries),
    .addr_i    (debug_i.addr),
    .data_o    (debugRdData_o)
  );

endmodule : physRegFile

`default_nettype wire

/* hdl/prfReadMux.sv */
// Combinational read where the highest set address bit wins and an empty address reads entry 0
`default_nettype none

module prfReadMux
  import prfPkg::*;
(
  input  wire prfData_t [numEntries-1:0] entries_i,
  input  wire prfOneHot_t                addr_i,

  output prfData_t                       data_o
);

  always_comb
  begin
    data_o = entries_i[0];            // Default when no bit is set

    // Upward scan so a higher bit overrides a lower one
    for (int i = 1; i < numEntries; i++)
    begin
      if (addr_i[i])
      begin
        data_o = entries_i[i];
      end
    end
  end

endmodule : prfReadMux

`default_nettype wire

/* hdl/prfStorage.sv */
// Entry array cleared by synchronous reset and written one edge after the enables are presented
`default_nettype none

module prfStorage
  import prfPkg::*;
(
  input  wire                            clk,
  input  wire                            reset,

  input  wire prfOneHot_t                entryWe_i,
  input  wire prfData_t [numEntries-1:0] entryData_i,

  output prfData_t      [numEntries-1:0] entries_o
);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      // Every entry reads as zero after reset
      entries_o <= '0;
    end
    else
    begin
      for (int e = 0; e < numEntries; e++)
      begin
        if (entryWe_i[e])
        begin
          entries_o[e] <= entryData_i[e];
        end
      end
    end
  end

endmodule : prfStorage

`default_nettype wire

/* hdl/prfWriteSelect.sv */
// Purely combinational write arbitration where debug beats lane 1 and lane 1 beats lane 0
`default_nettype none

module prfWriteSelect
  import prfPkg::*;
(
  input  wire prfWrite_t [issueWidth-1:0] laneWrite_i,
  input  wire prfDebug_t                  debug_i,

  output prfOneHot_t                      entryWe_o,
  output prfData_t   [numEntries-1:0]     entryData_o
);

  // All write requests in rising priority order
  prfWrite_t [numWritePorts-1:0] req;

  always_comb
  begin
    for (int p = 0; p < issueWidth; p++)
    begin
      req[p] = laneWrite_i[p];
    end

    // Debug sits in the top slot
    req[numWritePorts-1].we   = debug_i.we;
    req[numWritePorts-1].addr = debug_i.addr;
    req[numWritePorts-1].data = debug_i.wrData;
  end

  // Per entry the last matching request in the scan wins
  always_comb
  begin
    entryWe_o   = '0;
    entryData_o = '0;

    for (int e = 0; e < numEntries; e++)
    begin
      for (int p = 0; p < numWritePorts; p++)
      begin
        if (req[p].we && req[p].addr[e])
        begin
          entryWe_o[e]   = 1'b1;
          entryData_o[e] = req[p].data;   // Overrides lower ports
        end
      end
    end
  end

endmodule : prfWriteSelect

`default_nettype wire

/* hdl/prfPkg.sv */
// Sizes and port types for a two-lane 16-entry register file addressed by one-hot vectors
`default_nettype none

package prfPkg;

  // Geometry
  localparam int numEntries    = 16;
  localparam int dataWidth     = 16;
  localparam int issueWidth    = 2;
  localparam int numWritePorts = issueWidth + 1;  // Lanes plus debug

  typedef logic [dataWidth-1:0]  prfData_t;
  typedef logic [numEntries-1:0] prfOneHot_t;     // Fully decoded entry address

  // Destination write from one issue lane
  typedef struct packed {
    logic       we;
    prfOneHot_t addr;
    prfData_t   data;
  } prfWrite_t;

  // Source addresses of one lane
  typedef struct packed {
    prfOneHot_t src1;
    prfOneHot_t src2;
  } prfLaneRead_t;

  // Source operands returned to one lane
  typedef struct packed {
    prfData_t src1;
    prfData_t src2;
  } prfLaneData_t;

  // Debug access with one address shared by read and write
  typedef struct packed {
    logic       we;
    prfOneHot_t addr;
    prfData_t   wrData;
  } prfDebug_t;

endpackage : prfPkg

`default_nettype wire
